// File: source/pcu_spr_pkg.sv
// SPR bus definitions for the PCU

package pcu_spr_pkg;

  // SPR address split: group in the upper bits, offset below
  localparam int SPR_ADDR_W   = 16;
  localparam int SPR_DATA_W   = 32;
  localparam int SPR_OFFSET_W = 11;
  localparam int SPR_GROUP_W  = SPR_ADDR_W - SPR_OFFSET_W;

  // Performance counter group
  localparam logic [SPR_GROUP_W-1:0] SPR_GROUP_PCU = 5'd8;

  // Register bases inside the group, eight slots each
  localparam logic [SPR_OFFSET_W-1:0] PCCR_BASE = 11'd0;
  localparam logic [SPR_OFFSET_W-1:0] PCMR_BASE = 11'd8;

  // Architectural limit on counter pairs
  localparam int MAX_COUNTERS = 8;

  // One SPR bus request as driven by the core
  typedef struct packed {
    logic                  access;
    logic                  we;
    logic                  re;
    logic [SPR_ADDR_W-1:0] addr;
    logic [SPR_DATA_W-1:0] wdata;
  } spr_req_t;

endpackage

// File: source/pcu_event_pkg.sv
// PCU event vector and mode register layout

package pcu_event_pkg;

  // Core event vector, load is the LSB
  typedef struct packed {
    logic datadep_stall;
    logic itlb_miss;
    logic dtlb_miss;
    logic brn_stall;
    logic lsu_stall;
    logic ifetch_stall;
    logic icache_miss;
    logic dcache_miss;
    logic ifetch;
    logic store;
    logic load;
  } pcu_events_t;

  localparam int NUM_EVENTS = $bits(pcu_events_t);

  // PCMR bit positions
  localparam int PCMR_CP      = 0;
  localparam int PCMR_CISM    = 2;
  localparam int PCMR_CIUM    = 3;

  // Event selects, same order as the event vector
  localparam int PCMR_EVT_LSB = 4;

  // Software writable range, also covers the WPE field
  localparam int PCMR_WR_LSB  = 1;
  localparam int PCMR_WR_MSB  = 25;

  // Counter present is the only bit set out of reset
  localparam logic [31:0] PCMR_RESET = 32'(1) << PCMR_CP;

endpackage

// File: source/pcu_spr_slave.sv
// PCU SPR bus decode and read mux

`timescale 1ns/1ps

module pcu_spr_slave #(
  parameter int PCU_NUM_COUNTERS = 8
) (
  input  pcu_spr_pkg::spr_req_t              spr_req_i,
  input  logic                               sys_mode_i,
  input  logic [PCU_NUM_COUNTERS-1:0][31:0]  pccr_i,
  input  logic [PCU_NUM_COUNTERS-1:0][31:0]  pcmr_i,
  output logic                               spr_ack_o,
  output logic [31:0]                        spr_rdata_o,
  output logic [PCU_NUM_COUNTERS-1:0]        pccr_we_o,
  output logic [PCU_NUM_COUNTERS-1:0]        pcmr_we_o,
  output logic [31:0]                        wdata_o
);

  localparam int IDX_W = $clog2(pcu_spr_pkg::MAX_COUNTERS);
  localparam int OFS_W = pcu_spr_pkg::SPR_OFFSET_W;
  localparam int ADR_W = pcu_spr_pkg::SPR_ADDR_W;

  logic [pcu_spr_pkg::SPR_GROUP_W-1:0] spr_group;
  logic [OFS_W-1:0]                    spr_offset;
  logic [IDX_W-1:0]                    reg_idx;
  logic                                group_hit;
  logic                                pccr_hit;
  logic                                pcmr_hit;
  logic                                wr_en;
  logic                                rd_en;
  logic [PCU_NUM_COUNTERS-1:0]         idx_sel;

  assign spr_group  = spr_req_i.addr[ADR_W-1:OFS_W];
  assign spr_offset = spr_req_i.addr[OFS_W-1:0];
  assign reg_idx    = spr_offset[IDX_W-1:0];

  // Register kind from the offset bits above the index
  assign group_hit = (spr_group == pcu_spr_pkg::SPR_GROUP_PCU);
  assign pccr_hit  = group_hit &&
                     (spr_offset[OFS_W-1:IDX_W] == pcu_spr_pkg::PCCR_BASE[OFS_W-1:IDX_W]);
  assign pcmr_hit  = group_hit &&
                     (spr_offset[OFS_W-1:IDX_W] == pcu_spr_pkg::PCMR_BASE[OFS_W-1:IDX_W]);

  // Writes only from supervisor mode
  assign wr_en = spr_req_i.access & spr_req_i.we & sys_mode_i;
  assign rd_en = spr_req_i.access & spr_req_i.re;

  // One-hot index, indices past the last counter select nothing
  always_comb begin
    for (int i = 0; i < PCU_NUM_COUNTERS; i++) begin
      idx_sel[i] = (reg_idx == IDX_W'(i));
    end
  end

  assign pccr_we_o = idx_sel & {PCU_NUM_COUNTERS{wr_en & pccr_hit}};
  assign pcmr_we_o = idx_sel & {PCU_NUM_COUNTERS{wr_en & pcmr_hit}};
  assign wdata_o   = spr_req_i.wdata;

  // Acknowledge every access in the same cycle
  assign spr_ack_o = spr_req_i.access;

  always_comb begin
    spr_rdata_o = '0;
    for (int i = 0; i < PCU_NUM_COUNTERS; i++) begin
      if (rd_en && pccr_hit && idx_sel[i]) begin
        spr_rdata_o = pccr_i[i];
      end
      // Mode registers are hidden from user mode
      if (rd_en && pcmr_hit && sys_mode_i && idx_sel[i]) begin
        spr_rdata_o = pcmr_i[i];
      end
    end
  end

endmodule

// File: source/pcu_counter.sv
// PCU counter and mode register pair

`timescale 1ns/1ps

module pcu_counter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       pccr_we_i,
  input  logic                       pcmr_we_i,
  input  logic [31:0]                wdata_i,
  input  logic                       sys_mode_i,
  input  pcu_event_pkg::pcu_events_t events_i,
  output logic [31:0]                pccr_o,
  output logic [31:0]                pcmr_o
);

  localparam int NEVT = pcu_event_pkg::NUM_EVENTS;

  // Bits 25 to 1 of the mode register
  localparam logic [31:0] PCMR_WR_MASK =
    ((32'(1) << (pcu_event_pkg::PCMR_WR_MSB + 1)) - 32'(1)) &
    ~((32'(1) << pcu_event_pkg::PCMR_WR_LSB) - 32'(1));

  logic [31:0]     pccr_q;
  logic [31:0]     pcmr_q;
  logic [NEVT-1:0] evt_sel;
  logic            evt_hit;
  logic            mode_en;
  logic            count_en;

  assign evt_sel = pcmr_q[pcu_event_pkg::PCMR_EVT_LSB +: NEVT];

  // Coinciding events still count once
  assign evt_hit = |(evt_sel & events_i);

  assign mode_en = (pcmr_q[pcu_event_pkg::PCMR_CISM] & sys_mode_i) |
                   (pcmr_q[pcu_event_pkg::PCMR_CIUM] & ~sys_mode_i);

  assign count_en = mode_en & evt_hit;

  // A software write wins over the increment
  always_ff @(posedge clk) begin
    if (rst) begin
      pccr_q <= '0;
    end else if (pccr_we_i) begin
      pccr_q <= wdata_i;
    end else if (count_en) begin
      pccr_q <= pccr_q + 32'd1;
    end
  end

  // Counter present bit is held set
  always_ff @(posedge clk) begin
    if (rst) begin
      pcmr_q <= pcu_event_pkg::PCMR_RESET;
    end else if (pcmr_we_i) begin
      pcmr_q <= (wdata_i & PCMR_WR_MASK) | pcu_event_pkg::PCMR_RESET;
    end
  end

  assign pccr_o = pccr_q;
  assign pcmr_o = pcmr_q;

endmodule

// File: source/pcu_top.sv
// Performance counter unit top level

`timescale 1ns/1ps

module pcu_top #(
  parameter int PCU_NUM_COUNTERS = 8
) (
  input  logic                       clk,
  input  logic                       rst,
  input  pcu_spr_pkg::spr_req_t      spr_req_i,
  input  logic                       sys_mode_i,
  input  pcu_event_pkg::pcu_events_t events_i,
  output logic                       spr_ack_o,
  output logic [31:0]                spr_rdata_o
);

  logic [PCU_NUM_COUNTERS-1:0]       pccr_we;
  logic [PCU_NUM_COUNTERS-1:0]       pcmr_we;
  logic [31:0]                       wdata;
  logic [PCU_NUM_COUNTERS-1:0][31:0] pccr;
  logic [PCU_NUM_COUNTERS-1:0][31:0] pcmr;

  pcu_spr_slave #(
    .PCU_NUM_COUNTERS (PCU_NUM_COUNTERS)
  ) u_spr_slave (
    .spr_req_i   (spr_req_i),
    .sys_mode_i  (sys_mode_i),
    .pccr_i      (pccr),
    .pcmr_i      (pcmr),
    .spr_ack_o   (spr_ack_o),
    .spr_rdata_o (spr_rdata_o),
    .pccr_we_o   (pccr_we),
    .pcmr_we_o   (pcmr_we),
    .wdata_o     (wdata)
  );

  // One counter pair per implemented index
  for (genvar i = 0; i < PCU_NUM_COUNTERS; i++) begin : g_counter
    pcu_counter u_counter (
      .clk        (clk),
      .rst        (rst),
      .pccr_we_i  (pccr_we[i]),
      .pcmr_we_i  (pcmr_we[i]),
      .wdata_i    (wdata),
      .sys_mode_i (sys_mode_i),
      .events_i   (events_i),
      .pccr_o     (pccr[i]),
      .pcmr_o     (pcmr[i])
    );
  end

endmodule

// File: sim/pcu_props.sv
// PCU SPR bus assertions

`timescale 1ns/1ps

module pcu_props (
  input logic                  clk,
  input logic                  rst,
  input pcu_spr_pkg::spr_req_t spr_req_i,
  input logic                  sys_mode_i,
  input logic                  spr_ack_o,
  input logic [31:0]           spr_rdata_o
);

  int fail_cnt = 0;

  // Acknowledge tracks the access strobe in the same cycle
  a_ack_follows_access: assert property (@(posedge clk) disable iff (rst)
    spr_ack_o == spr_req_i.access)
  else begin
    fail_cnt++;
    $error("spr_ack_o differs from the access strobe");
  end

  // Read data stays zero without a read request
  a_rdata_idle_zero: assert property (@(posedge clk) disable iff (rst)
    !(spr_req_i.access && spr_req_i.re) |-> spr_rdata_o == '0)
  else begin
    fail_cnt++;
    $error("spr_rdata_o is nonzero without a read");
  end

  // Mode registers are not visible from user mode
  a_pcmr_user_zero: assert property (@(posedge clk) disable iff (rst)
    (spr_req_i.access && spr_req_i.re && !sys_mode_i &&
     spr_req_i.addr[15:11] == pcu_spr_pkg::SPR_GROUP_PCU &&
     spr_req_i.addr[10:3] == pcu_spr_pkg::PCMR_BASE[10:3]) |-> spr_rdata_o == '0)
  else begin
    fail_cnt++;
    $error("PCMR read in user mode returned data");
  end

endmodule

bind pcu_top pcu_props i_pcu_props (.*);

// File: sim/pcu_tb.sv
// PCU testbench

`timescale 1ns/1ps

module pcu_tb;

  localparam int NUM_COUNTERS = 6;
  localparam int RAND_CYCLES  = 200;
  localparam bit SUP = 1'b1;
  localparam bit USR = 1'b0;

  // Group 8 puts the PCU at 0x4000
  localparam logic [15:0] PCCR_ADDR = 16'h4000;
  // Mode registers from offset 8
  localparam logic [15:0] PCMR_ADDR = 16'h4008;

  typedef enum logic [1:0] {OP_IDLE, OP_READ, OP_WRITE} op_e;

  typedef struct packed {
    op_e         op;
    logic [15:0] addr;
    logic [31:0] data;
    logic        mode;
    logic [10:0] ev;
    logic [31:0] exp;
  } step_t;

  localparam int NUM_STEPS = 36;
  localparam int CYCLE_LIMIT = NUM_STEPS + RAND_CYCLES + 50;

  // op, address, write data, mode, events, expected read data
  localparam step_t STEPS [NUM_STEPS] = '{
    '{OP_WRITE, 16'h4002, 32'hDEADBEEF, SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h4002, 32'h0,        SUP, 11'h000, 32'hDEADBEEF},
    '{OP_WRITE, 16'h4009, 32'hFFFF8002, SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h4009, 32'h0,        SUP, 11'h000, 32'h03FF8003},
    // User mode writes are dropped
    '{OP_WRITE, 16'h4002, 32'h12345678, USR, 11'h000, 32'h0},
    '{OP_READ,  16'h4002, 32'h0,        USR, 11'h000, 32'hDEADBEEF},
    '{OP_WRITE, 16'h4009, 32'h00000030, USR, 11'h000, 32'h0},
    '{OP_READ,  16'h4009, 32'h0,        USR, 11'h000, 32'h0},
    '{OP_READ,  16'h4009, 32'h0,        SUP, 11'h000, 32'h03FF8003},
    // Counter 0 counts load or store in supervisor mode
    '{OP_WRITE, 16'h4008, 32'h00000034, SUP, 11'h000, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        SUP, 11'h003, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        SUP, 11'h001, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        SUP, 11'h400, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        USR, 11'h003, 32'h0},
    '{OP_READ,  16'h4000, 32'h0,        SUP, 11'h000, 32'h00000002},
    '{OP_READ,  16'h4008, 32'h0,        SUP, 11'h000, 32'h00000035},
    '{OP_WRITE, 16'h4000, 32'h00000100, SUP, 11'h001, 32'h0},
    '{OP_READ,  16'h4000, 32'h0,        SUP, 11'h000, 32'h00000100},
    // Counter 3 counts dcache misses in user mode only
    '{OP_WRITE, 16'h400B, 32'h00000088, SUP, 11'h000, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        SUP, 11'h008, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        USR, 11'h008, 32'h0},
    '{OP_READ,  16'h4003, 32'h0,        USR, 11'h000, 32'h00000001},
    // Unmapped addresses
    '{OP_WRITE, 16'h4800, 32'h00005555, SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h4800, 32'h0,        SUP, 11'h000, 32'h0},
    '{OP_WRITE, 16'h4006, 32'h0000AAAA, SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h4006, 32'h0,        SUP, 11'h000, 32'h0},
    '{OP_WRITE, 16'h400E, 32'hFFFFFFFF, SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h400F, 32'h0,        SUP, 11'h000, 32'h0},
    '{OP_WRITE, 16'h4010, 32'h00007777, SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h4010, 32'h0,        SUP, 11'h000, 32'h0},
    '{OP_READ,  16'h0008, 32'h0,        SUP, 11'h000, 32'h0},
    '{OP_IDLE,  16'h0000, 32'h0,        USR, 11'h003, 32'h0},
    '{OP_READ,  16'h4000, 32'h0,        SUP, 11'h000, 32'h00000100},
    '{OP_READ,  16'h4008, 32'h0,        SUP, 11'h000, 32'h00000035},
    '{OP_READ,  16'h4002, 32'h0,        SUP, 11'h000, 32'hDEADBEEF},
    '{OP_READ,  16'h4001, 32'h0,        SUP, 11'h000, 32'h0}
  };

  // One random phase mask per counter
  localparam logic [31:0] RAND_MASK [NUM_COUNTERS] = '{
    32'h00000034, 32'h00007FFC, 32'h00000408,
    32'h000040C4, 32'h0000000C, 32'h00001F0C
  };

  logic                       clk;
  logic                       rst;
  pcu_spr_pkg::spr_req_t      spr_req;
  logic                       sys_mode;
  pcu_event_pkg::pcu_events_t events;
  logic                       spr_ack;
  logic [31:0]                spr_rdata;

  int          cycle_cnt = 0;
  logic [31:0] seed;
  logic [31:0] ref_cnt [NUM_COUNTERS];

  pcu_top #(
    .PCU_NUM_COUNTERS (NUM_COUNTERS)
  ) i_dut (
    .clk         (clk),
    .rst         (rst),
    .spr_req_i   (spr_req),
    .sys_mode_i  (sys_mode),
    .events_i    (events),
    .spr_ack_o   (spr_ack),
    .spr_rdata_o (spr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1, "Timeout");
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Privilege enable matches and a selected event is present
  function automatic bit count_hit(input logic [31:0] mask, input logic mode,
                                   input logic [10:0] ev);
    bit mode_ok;
    mode_ok = (mode && mask[2]) || (!mode && mask[3]);
    return mode_ok && ((mask[14:4] & ev) != 11'd0);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "Value mismatch");
    end
  endtask

  // One bus cycle with outputs checked mid-cycle
  task automatic run_step(input op_e op, input logic [15:0] addr, input logic [31:0] data,
                          input logic mode, input logic [10:0] ev,
                          input logic [31:0] exp);
    pcu_spr_pkg::spr_req_t req;
    req.access = (op != OP_IDLE);
    req.we     = (op == OP_WRITE);
    req.re     = (op == OP_READ);
    req.addr   = addr;
    req.wdata  = data;
    @(posedge clk);
    spr_req  <= req;
    sys_mode <= mode;
    events   <= ev;
    @(negedge clk);
    check_value("spr_ack_o", {31'd0, spr_ack}, {31'd0, op != OP_IDLE});
    check_value("spr_rdata_o", spr_rdata, exp);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst      = 1'b1;
    spr_req  = '0;
    sys_mode = 1'b1;
    events   = '0;
    seed     = 32'h2b11;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Reset values
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      run_step(OP_READ, PCCR_ADDR + 16'(i), 32'h0, SUP, 11'h000, 32'h0);
      run_step(OP_READ, PCMR_ADDR + 16'(i), 32'h0, SUP, 11'h000, 32'h00000001);
    end

    for (int k = 0; k < NUM_STEPS; k++) begin
      run_step(STEPS[k].op, STEPS[k].addr, STEPS[k].data, STEPS[k].mode,
               STEPS[k].ev, STEPS[k].exp);
    end

    for (int i = 0; i < NUM_COUNTERS; i++) begin
      run_step(OP_WRITE, PCMR_ADDR + 16'(i), RAND_MASK[i], SUP, 11'h000, 32'h0);
      run_step(OP_WRITE, PCCR_ADDR + 16'(i), 32'h0, SUP, 11'h000, 32'h0);
      ref_cnt[i] = 32'h0;
    end

    // Random events and privilege
    for (int c = 0; c < RAND_CYCLES; c++) begin
      seed = lcg_next(seed);
      run_step(OP_IDLE, 16'h0000, 32'h0, seed[31], seed[26:16], 32'h0);
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (count_hit(RAND_MASK[i], seed[31], seed[26:16])) begin
          ref_cnt[i] = ref_cnt[i] + 32'd1;
        end
      end
    end

    for (int i = 0; i < NUM_COUNTERS; i++) begin
      run_step(OP_READ, PCCR_ADDR + 16'(i), 32'h0, SUP, 11'h000, ref_cnt[i]);
      run_step(OP_READ, PCMR_ADDR + 16'(i), 32'h0, SUP, 11'h000,
               (RAND_MASK[i] & 32'h03FFFFFE) | 32'h00000001);
    end

    if (i_dut.i_pcu_props.fail_cnt != 0) begin
      $display("Errors found");
      $fatal(1, "Assertion failures");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: project.f
source/pcu_spr_pkg.sv
source/pcu_event_pkg.sv
source/pcu_spr_slave.sv
source/pcu_counter.sv
source/pcu_top.sv
sim/pcu_props.sv
sim/pcu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PCU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module pcu_tb -o pcu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/pcu_sim 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
